// File: source/dmem_consts.svh
/* Widths and size codes for the data-memory port.
   Included by the RTL and the testbench wherever these values are needed. */

`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

// Word geometry.
`define DMEM_DATA_WIDTH 32
`define DMEM_ADDR_WIDTH 10  // Word address bits, 1024 words in total.
`define DMEM_BYTES      4   // Byte lanes per word.

// Access size codes carried on the size input.
`define DMEM_SIZE_BYTE 2'd0
`define DMEM_SIZE_HALF 2'd1
`define DMEM_SIZE_WORD 2'd2
// Code 3 is not a legal size and is handled as a misaligned request.

`endif

// File: source/dmem_pkg.sv
/* Types shared by the RAM, the memory bus interface and the access and load units.
   Imported by wildcard in the header of each module that uses them. */

`include "dmem_consts.svh"

package dmem_pkg;

    // A memory word is read either as one value or as its byte lanes.
    // Lane 0 holds the least significant byte, matching a little-endian core.
    typedef logic [7:0] lane_t;

    typedef union packed {
        lane_t [`DMEM_BYTES-1:0]       bytes;  // Per-lane view for byte writes.
        logic [`DMEM_DATA_WIDTH-1:0]   word;   // Whole-word view.
    } mem_word_t;

endpackage

// File: source/dmem_bus_if.sv
/* Internal bus between the access unit, the RAM and the load unit.
   The access unit drives the write side, the RAM returns the read word. */

`include "dmem_consts.svh"

interface dmem_bus_if import dmem_pkg::*; ();

    logic [`DMEM_BYTES-1:0]      be;         // One write enable per byte lane.
    logic [`DMEM_ADDR_WIDTH-1:0] word_addr;  // Shared by reads and writes.
    mem_word_t                   wdata;      // Already replicated across the lanes.
    mem_word_t                   rdata;      // Combinational read of word_addr.

    // Request side, owned by the access unit.
    modport ctrl (
        output be,
        output word_addr,
        output wdata
    );

    // Storage side.
    modport ram (
        input  be,
        input  word_addr,
        input  wdata,
        output rdata
    );

    // The load unit only looks at the returned word.
    modport mon (
        input rdata
    );

endinterface

// File: source/lutram.sv
/* Byte-writable distributed RAM with a read that returns data in the same cycle.
   Writes land on the rising edge for every lane whose enable is set. */

`include "dmem_consts.svh"

module lutram import dmem_pkg::*; (
    input logic clk,
    dmem_bus_if.ram bus
);

    localparam int MEM_WORDS = 1 << `DMEM_ADDR_WIDTH;

    mem_word_t mem [MEM_WORDS];

    // Asynchronous read. A store and a read of the same word in one cycle
    // return the old contents, as a read-first distributed RAM does.
    assign bus.rdata = mem[bus.word_addr];

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DMEM_BYTES; i++) begin
            if (bus.be[i]) begin
                mem[bus.word_addr].bytes[i] <= bus.wdata.bytes[i];
            end
        end
    end

    // The enables come from the access unit.
    // An unknown lane enable would corrupt a word silently.
    be_known_a: assert property (@(posedge clk) !$isunknown(bus.be))
        else $error("lutram: byte enables unknown at clock edge");

endmodule

// File: source/access_unit.sv
/* Decodes a memory request into lane enables, a word address and store data.
   Misaligned requests never reach the RAM and raise a one-cycle fault instead. */

`include "dmem_consts.svh"

module access_unit import dmem_pkg::*; (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req,         // One-cycle request strobe.
    input  logic                        we,
    input  logic [1:0]                  size,
    input  logic [`DMEM_ADDR_WIDTH+1:0] addr,        // Byte address.
    input  logic [`DMEM_DATA_WIDTH-1:0] store_data,
    dmem_bus_if.ctrl                    bus,
    output logic                        fault
);

    logic [1:0]             offset;
    logic                   aligned;
    logic                   store;
    logic [`DMEM_BYTES-1:0] lane_mask;
    mem_word_t              store_word;

    assign offset = addr[1:0];

    // A halfword must start on an even byte, a word on a word boundary.
    always_comb begin
        case (size)
            `DMEM_SIZE_BYTE: aligned = 1'b1;
            `DMEM_SIZE_HALF: aligned = ~offset[0];
            `DMEM_SIZE_WORD: aligned = (offset == 2'b00);
            default:         aligned = 1'b0;
        endcase
    end

    assign store = req & we & aligned;

    // Lanes covered by the access, shifted to the addressed offset.
    always_comb begin
        case (size)
            `DMEM_SIZE_BYTE: lane_mask = 4'b0001 << offset;
            `DMEM_SIZE_HALF: lane_mask = 4'b0011 << offset;
            `DMEM_SIZE_WORD: lane_mask = 4'b1111;
            default:         lane_mask = 4'b0000;
        endcase
    end

    assign bus.be        = store ? lane_mask : '0;
    assign bus.word_addr = addr[`DMEM_ADDR_WIDTH+1:2];

    // The store value is copied to every lane so that the enables alone
    // pick where it lands in the word.
    assign store_word.word = store_data;

    always_comb begin
        for (int i = 0; i < `DMEM_BYTES; i++) begin
            case (size)
                `DMEM_SIZE_BYTE: bus.wdata.bytes[i] = store_word.bytes[0];
                `DMEM_SIZE_HALF: bus.wdata.bytes[i] = store_word.bytes[i % 2];
                default:         bus.wdata.bytes[i] = store_word.bytes[i];
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fault <= 1'b0;
        end else begin
            fault <= req & ~aligned;  // Loads and stores fault alike.
        end
    end

    // Unknown controls on a request would turn the lane decode into unknown enables.
    req_known_a: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(req) && (!req || !$isunknown({we, size, addr})))
        else $error("access_unit: request controls unknown at clock edge");

endmodule

// File: source/load_unit.sv
/* Picks the addressed lanes out of the RAM word and extends them to 32 bits.
   The result is registered and flagged by a one-cycle load_valid. */

`include "dmem_consts.svh"

module load_unit import dmem_pkg::*; (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req,
    input  logic                        we,
    input  logic [1:0]                  size,
    input  logic                        is_unsigned,
    input  logic [`DMEM_ADDR_WIDTH+1:0] addr,
    dmem_bus_if.mon                     bus,
    output logic [`DMEM_DATA_WIDTH-1:0] load_data,
    output logic                        load_valid
);

    logic                        aligned;
    logic                        load;
    lane_t                       sel_byte;
    logic [15:0]                 sel_half;
    logic [`DMEM_DATA_WIDTH-1:0] ext_data;

    // Alignment here only withholds load_valid. The access unit raises the fault.
    always_comb begin
        case (size)
            `DMEM_SIZE_BYTE: aligned = 1'b1;
            `DMEM_SIZE_HALF: aligned = ~addr[0];
            `DMEM_SIZE_WORD: aligned = (addr[1:0] == 2'b00);
            default:         aligned = 1'b0;
        endcase
    end

    assign load = req & ~we & aligned;

    assign sel_byte = bus.rdata.bytes[addr[1:0]];
    assign sel_half = {bus.rdata.bytes[{addr[1], 1'b1}], bus.rdata.bytes[{addr[1], 1'b0}]};

    always_comb begin
        case (size)
            `DMEM_SIZE_BYTE: ext_data = is_unsigned ? {24'b0, sel_byte}
                                                    : {{24{sel_byte[7]}}, sel_byte};
            `DMEM_SIZE_HALF: ext_data = is_unsigned ? {16'b0, sel_half}
                                                    : {{16{sel_half[15]}}, sel_half};
            default:         ext_data = bus.rdata.word;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_valid <= 1'b0;
            load_data  <= '0;
        end else begin
            load_valid <= load;
            if (load) begin
                load_data <= ext_data;  // Held until the next load.
            end
        end
    end

    // A load must not pick up unknown bits, such as lanes that were never written.
    load_known_a: assert property (@(posedge clk) disable iff (!arst_n)
        load |-> !$isunknown(ext_data))
        else $error("load_unit: load returned unknown data");

endmodule

// File: source/dmem_subsystem.sv
/* Top level of the data-memory port.
   Requests enter on plain ports, the units share one internal bus. */

`include "dmem_consts.svh"

module dmem_subsystem (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req,
    input  logic                        we,
    input  logic [1:0]                  size,
    input  logic                        is_unsigned,
    input  logic [`DMEM_ADDR_WIDTH+1:0] addr,
    input  logic [`DMEM_DATA_WIDTH-1:0] store_data,
    output logic [`DMEM_DATA_WIDTH-1:0] load_data,
    output logic                        load_valid,
    output logic                        fault
);

    dmem_bus_if bus_i ();

    access_unit access_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .we         (we),
        .size       (size),
        .addr       (addr),
        .store_data (store_data),
        .bus        (bus_i.ctrl),
        .fault      (fault)
    );

    lutram ram_i (
        .clk (clk),
        .bus (bus_i.ram)
    );

    load_unit load_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .we          (we),
        .size        (size),
        .is_unsigned (is_unsigned),
        .addr        (addr),
        .bus         (bus_i.mon),
        .load_data   (load_data),
        .load_valid  (load_valid)
    );

endmodule

// File: bench/dmem_checker.sv
/* Watches the DUT outputs and compares each response with the expected one.
   Takes a request when start is high at a rising edge and samples on falling edges. */

`include "dmem_consts.svh"

module dmem_checker (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [`DMEM_DATA_WIDTH-1:0] load_data,
    input  logic                        load_valid,
    input  logic                        fault,
    input  logic                        start,
    input  logic [7:0]                  test_code,
    input  logic [1:0]                  exp_kind,
    input  logic [`DMEM_DATA_WIDTH-1:0] exp_value,
    output int                          checked,     // Requests judged so far.
    output int                          pass_count,
    output int                          fail_count
);

    localparam logic [1:0] KIND_NONE  = 2'd0;
    localparam logic [1:0] KIND_FAULT = 2'd2;
    localparam int         RESP_LIMIT = 10;

    task automatic print_summary();
        $display("passed %0d, failed %0d", pass_count, fail_count);
    endtask

    task automatic check_reset();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (arst_n !== 1'b1 && cycles < 2 * RESP_LIMIT);
        @(negedge clk);
        if (arst_n !== 1'b1) begin
            $display("reset was never released");
            fail_count++;
        end else if (load_valid !== 1'b0 || fault !== 1'b0 || load_data !== '0) begin
            $display("error at %0t: outputs not cleared by reset, data %h valid %b fault %b",
                     $time, load_data, load_valid, fault);
            fail_count++;
        end else begin
            $display("test reset ok");
            pass_count++;
        end
    endtask

    // Stores and faults must leave load_data at the last loaded value.
    task automatic check_response(input logic [7:0] code, input logic [1:0] kind,
                                  input logic [`DMEM_DATA_WIDTH-1:0] want,
                                  input logic [`DMEM_DATA_WIDTH-1:0] held);
        if (kind == KIND_NONE && load_valid === 1'b0 && fault === 1'b0
            && load_data === held) begin
            $display("test %h store ok", code);
            pass_count++;
        end else if (kind == KIND_NONE) begin
            $display("error at %0t: test %h store gave data %h valid %b fault %b, held %h",
                     $time, code, load_data, load_valid, fault, held);
            fail_count++;
        end else if (load_valid !== 1'b1 && fault !== 1'b1) begin
            $display("test %h failed, no load_valid or fault within %0d cycles",
                     code, RESP_LIMIT);
            fail_count++;
        end else if (kind == KIND_FAULT && fault === 1'b1 && load_valid === 1'b0
                     && load_data === held) begin
            $display("test %h fault ok", code);
            pass_count++;
        end else if (kind != KIND_FAULT && load_valid === 1'b1 && fault === 1'b0
                     && load_data === want) begin
            $display("test %h load ok, data %h", code, load_data);
            pass_count++;
        end else begin
            $display("error at %0t: test %h got data %h valid %b fault %b, expected %h kind %0d",
                     $time, code, load_data, load_valid, fault, want, kind);
            $display("error at %0t: test %h data held from the last load is %h",
                     $time, code, held);
            fail_count++;
        end
    endtask

    initial begin
        logic [7:0]                  code;
        logic [1:0]                  kind;
        logic [`DMEM_DATA_WIDTH-1:0] want;
        logic [`DMEM_DATA_WIDTH-1:0] held;  // Value of the last load, zero after reset.
        int                          cycles;
        checked    = 0;
        pass_count = 0;
        fail_count = 0;
        held       = '0;
        check_reset();
        forever begin
            @(posedge clk);
            if (start === 1'b1) begin
                code   = test_code;
                kind   = exp_kind;
                want   = exp_value;
                cycles = 0;
                // A store is judged one cycle later. A load or fault is judged once it shows up.
                do begin
                    @(negedge clk);
                    cycles++;
                end while (kind != KIND_NONE && load_valid !== 1'b1 && fault !== 1'b1
                           && cycles < RESP_LIMIT);
                check_response(code, kind, want, held);
                if (kind != KIND_NONE && kind != KIND_FAULT) begin
                    held = want;
                end
                checked++;
            end
        end
    end

endmodule

// File: bench/dmem_tb.sv
/* Testbench for the data-memory port. Reads one access per line from the cases file,
   drives it on a falling edge and hands the expected response to the checker. */

`include "dmem_consts.svh"

module dmem_tb;

    localparam logic [1:0] KIND_NONE  = 2'd0;
    localparam int         WAIT_LIMIT = 20;  // Cycles the checker may take to catch up.

    logic                        clk;
    logic                        arst_n;
    logic                        req;
    logic                        we;
    logic [1:0]                  size;
    logic                        is_unsigned;
    logic [`DMEM_ADDR_WIDTH+1:0] addr;
    logic [`DMEM_DATA_WIDTH-1:0] store_data;
    logic [`DMEM_DATA_WIDTH-1:0] load_data;
    logic                        load_valid;
    logic                        fault;
    logic                        start;  // Marks the cycle whose request the checker takes.
    logic [7:0]                  test_code;
    logic [1:0]                  exp_kind;
    logic [`DMEM_DATA_WIDTH-1:0] exp_value;
    logic                        timed_out;
    int                          issued;
    int                          checked;
    int                          pass_count;
    int                          fail_count;

    dmem_subsystem dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .we          (we),
        .size        (size),
        .is_unsigned (is_unsigned),
        .addr        (addr),
        .store_data  (store_data),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .fault       (fault)
    );

    dmem_checker chk_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .load_data  (load_data),
        .load_valid (load_valid),
        .fault      (fault),
        .start      (start),
        .test_code  (test_code),
        .exp_kind   (exp_kind),
        .exp_value  (exp_value),
        .checked    (checked),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic drive_idle();
        req         = 1'b0;
        start       = 1'b0;
        we          = 1'b0;
        size        = `DMEM_SIZE_BYTE;
        is_unsigned = 1'b0;
        addr        = '0;
        store_data  = '0;
    endtask

    // Blocks until every issued request has been judged.
    task automatic wait_for_checker();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (checked < issued && cycles < WAIT_LIMIT);
        if (checked < issued) begin
            $display("checker gave no verdict within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic apply_case(input logic [31:0] code, input logic [31:0] w,
                              input logic [31:0] sz, input logic [31:0] uns,
                              input logic [31:0] a, input logic [31:0] d,
                              input logic [31:0] kind, input logic [31:0] exp_val);
        @(negedge clk);
        req         = 1'b1;
        we          = w[0];
        size        = sz[1:0];
        is_unsigned = uns[0];
        addr        = a[`DMEM_ADDR_WIDTH+1:0];
        store_data  = d;
        start       = 1'b1;
        test_code   = code[7:0];
        exp_kind    = kind[1:0];
        exp_value   = exp_val;
        issued++;
        // A store gives no response, so the next request may follow at once.
        if (kind[1:0] != KIND_NONE) begin
            @(negedge clk);
            drive_idle();
            wait_for_checker();
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [31:0] f[8];
        issued    = 0;
        timed_out = 1'b0;
        arst_n    = 1'b0;
        test_code = '0;
        exp_kind  = KIND_NONE;
        exp_value = '0;
        drive_idle();
        fd = $fopen("bench/dmem_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/dmem_cases.txt");
            $display("tests failed");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            @(negedge clk);
            arst_n = 1'b1;
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() == 0 || line.getc(0) == "#") continue;
                if ($sscanf(line, "%h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]) != 8) continue;
                apply_case(f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            end
            $fclose(fd);
            if (!timed_out) begin
                @(negedge clk);
                drive_idle();
                wait_for_checker();
            end
            chk_i.print_summary();
            if (!timed_out && fail_count == 0 && issued > 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

// File: bench/dmem_cases.txt
# code we size is_unsigned addr store_data kind expected, all in hex
# size 0 byte, 1 half, 2 word, 3 illegal; kind 0 no response, 1 load, 2 fault
11 1 2 0 000 12345678 0 00000000
12 0 2 0 000 00000000 1 12345678
13 1 2 0 ffc cafef00d 0 00000000
14 0 2 0 ffc 00000000 1 cafef00d
21 1 2 0 020 11223344 0 00000000
22 1 0 0 020 123456aa 0 00000000
23 0 2 0 020 00000000 1 112233aa
24 1 0 0 021 abcdefbb 0 00000000
25 0 2 0 020 00000000 1 1122bbaa
26 1 0 0 022 000000cc 0 00000000
27 0 2 0 020 00000000 1 11ccbbaa
28 1 0 0 023 ffffffdd 0 00000000
29 0 2 0 020 00000000 1 ddccbbaa
31 1 1 0 040 00008001 0 00000000
32 1 1 0 042 ffff9abc 0 00000000
33 0 2 0 040 00000000 1 9abc8001
34 0 1 0 040 00000000 1 ffff8001
35 0 1 1 040 00000000 1 00008001
36 0 1 0 042 00000000 1 ffff9abc
37 0 1 1 042 00000000 1 00009abc
41 0 0 0 020 00000000 1 ffffffaa
42 0 0 1 020 00000000 1 000000aa
43 0 0 0 023 00000000 1 ffffffdd
44 0 0 1 022 00000000 1 000000cc
45 0 0 0 001 00000000 1 00000056
51 1 1 0 041 00001111 2 00000000
52 1 2 0 042 deadbeef 2 00000000
53 1 3 0 040 deadbeef 2 00000000
54 0 1 0 043 00000000 2 00000000
55 0 2 0 041 00000000 2 00000000
56 0 2 0 040 00000000 1 9abc8001
57 1 2 0 002 deadbeef 2 00000000
58 0 2 0 000 00000000 1 12345678
61 1 2 0 010 0badc0de 0 00000000
62 0 2 0 010 00000000 1 0badc0de
63 1 0 0 011 00000077 0 00000000
64 0 2 0 010 00000000 1 0bad77de
65 1 2 0 014 a5a5a5a5 0 00000000
66 1 1 0 016 00005a5a 0 00000000
67 0 1 1 016 00000000 1 00005a5a

// File: project.f
+incdir+source
source/dmem_pkg.sv
source/dmem_bus_if.sv
source/lutram.sv
source/access_unit.sv
source/load_unit.sv
source/dmem_subsystem.sv
bench/dmem_checker.sv
bench/dmem_tb.sv

// File: Bender.yml
package:
  name: dmem_port

export_include_dirs:
  - source

sources:
  - source/dmem_pkg.sv
  - source/dmem_bus_if.sv
  - source/lutram.sv
  - source/access_unit.sv
  - source/load_unit.sv
  - source/dmem_subsystem.sv
  - target: simulation
    files:
      - bench/dmem_checker.sv
      - bench/dmem_tb.sv
